/* design/ising_pkg.sv */
// sizes of the Ising core
// spin, energy, weight and bias types
// candidate struct and flip manager states

package ising_pkg;

    localparam int NUM_SPIN    = 16;
    localparam int BITJ        = 4;
    localparam int SCALING_BIT = 4;
    localparam int PARALLELISM = 4;

    // one J word carries PARALLELISM rows
    localparam int J_DEPTH  = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_W = $clog2(J_DEPTH);

    localparam int ENERGY_W = 32;

    localparam int FLIP_DEPTH  = 64;
    localparam int FLIP_ADDR_W = $clog2(FLIP_DEPTH);

    // bit 1 is spin +1, bit 0 is spin -1
    typedef logic [NUM_SPIN-1:0] spin_t;

    typedef logic signed [ENERGY_W-1:0] energy_t;

    // one signed coupling or bias value
    typedef logic signed [BITJ-1:0] coef_t;

    // field j of row i is J_ij
    typedef coef_t [NUM_SPIN-1:0] j_row_t;
    typedef j_row_t [PARALLELISM-1:0] j_word_t;

    typedef coef_t [NUM_SPIN-1:0] h_vec_t;

    typedef struct packed {
        spin_t   spin;
        energy_t energy;
    } cand_t;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_ENERGY,
        READ_FLIP,
        DONE
    } fm_state_e;

    // start value of the best energy
    localparam energy_t ENERGY_MAX = {1'b0, {(ENERGY_W-1){1'b1}}};

endpackage

/* design/weight_fetch.sv */
// J weight reader for the energy monitor
// cyclic read address counter and read-valid tracking
// two-entry prefetch FIFO with valid/ready output

module weight_fetch
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    output logic                j_ren_o,
    output logic [J_ADDR_W-1:0] j_raddr_o,
    input  j_word_t             j_rdata_i,
    output logic                word_valid_o,
    input  logic                word_ready_i,
    output j_word_t             word_o
);

    logic                ren_q;
    logic                rvalid_q;
    logic [J_ADDR_W-1:0] addr_q;
    logic [1:0]          count_q;
    logic                wr_ptr_q;
    logic                rd_ptr_q;
    logic                pop;
    logic [2:0]          pending;
    logic                ren_d;
    j_word_t             fifo_q [2];

    assign pop = word_valid_o & word_ready_i;

    // stored words plus reads still on their way, after this cycle's pop
    assign pending = {1'b0, count_q} + {2'b00, rvalid_q} + {2'b00, ren_q} - {2'b00, pop};
    assign ren_d   = pending < 3'd2;

    assign j_ren_o      = ren_q;
    assign j_raddr_o    = addr_q;
    assign word_valid_o = count_q != 2'd0;
    assign word_o       = fifo_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ren_q    <= 1'b0;
            rvalid_q <= 1'b0;
            addr_q   <= '0;
            count_q  <= 2'd0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
        end else begin
            ren_q    <= ren_d;
            rvalid_q <= ren_q;
            // wraps after the last word
            if (ren_q) begin
                if (addr_q == J_ADDR_W'(J_DEPTH - 1)) begin
                    addr_q <= '0;
                end else begin
                    addr_q <= addr_q + J_ADDR_W'(1);
                end
            end
            if (rvalid_q) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, rvalid_q} - {1'b0, pop};
        end
    end

    // read data lands one cycle after ren
    always_ff @(posedge clk_i) begin
        if (rvalid_q) begin
            fifo_q[wr_ptr_q] <= j_rdata_i;
        end
    end

endmodule

/* design/energy_monitor.sv */
// Ising energy of one candidate spin vector
// one J word per row group, bias scaled by a shared factor
// registered group term, signed accumulator, held result

module energy_monitor
    import ising_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   spin_valid_i,
    output logic                   spin_ready_o,
    input  spin_t                  spin_i,
    input  logic                   word_valid_i,
    output logic                   word_ready_o,
    input  j_word_t                word_i,
    input  h_vec_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    output logic                   result_valid_o,
    input  logic                   result_ready_i,
    output cand_t                  result_o
);

    spin_t               spin_q;
    logic                busy_q;
    logic                term_valid_q;
    logic                term_last_q;
    logic                done_q;
    logic [J_ADDR_W-1:0] grp_q;
    energy_t             term_q;
    energy_t             acc_q;
    energy_t             group_sum;
    energy_t             scale;
    logic                spin_hs;
    logic                word_hs;
    logic                result_hs;
    logic                last_grp;

    // no new spin until the previous result has left
    assign spin_ready_o = ~busy_q & ~term_valid_q & ~done_q;
    assign word_ready_o = busy_q;

    assign spin_hs   = spin_valid_i & spin_ready_o;
    assign word_hs   = word_valid_i & word_ready_o;
    assign result_hs = result_valid_o & result_ready_i;
    assign last_grp  = grp_q == J_ADDR_W'(J_DEPTH - 1);

    // scaling factor is unsigned
    assign scale = energy_t'(hscaling_i);

    // sigma_i * f_i summed over the rows of the current word
    always_comb begin : group_tree
        int      row_idx;
        energy_t field;

        group_sum = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            row_idx = int'(grp_q) * PARALLELISM + r;
            field   = scale * energy_t'(coef_t'(hbias_i[row_idx]));
            for (int j = 0; j < NUM_SPIN; j++) begin
                if (spin_q[j]) begin
                    field = field + energy_t'(coef_t'(word_i[r][j]));
                end else begin
                    field = field - energy_t'(coef_t'(word_i[r][j]));
                end
            end
            if (spin_q[row_idx]) begin
                group_sum = group_sum + field;
            end else begin
                group_sum = group_sum - field;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            term_valid_q <= 1'b0;
            done_q       <= 1'b0;
            grp_q        <= '0;
        end else begin
            if (spin_hs) begin
                busy_q <= 1'b1;
                grp_q  <= '0;
            end else if (word_hs) begin
                if (last_grp) begin
                    busy_q <= 1'b0;
                    grp_q  <= '0;
                end else begin
                    grp_q <= grp_q + J_ADDR_W'(1);
                end
            end
            term_valid_q <= word_hs;
            // last term is added on this edge
            if (term_valid_q && term_last_q) begin
                done_q <= 1'b1;
            end else if (result_hs) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end else if (term_valid_q) begin
            acc_q <= acc_q + term_q;
        end
        if (word_hs) begin
            term_q      <= group_sum;
            term_last_q <= last_grp;
        end
    end

    assign result_valid_o  = done_q;
    assign result_o.spin   = spin_q;
    assign result_o.energy = acc_q;

endmodule

/* design/flip_manager.sv */
// greedy search controller
// start edge detect, candidate issue, energy compare
// flip icon read and best result register

module flip_manager
    import ising_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cfg_valid_i,
    input  spin_t                  cfg_spin_i,
    input  logic                   cmpt_en_i,
    input  logic                   en_comparison_i,
    input  logic [FLIP_ADDR_W:0]   flip_count_i,
    output logic                   flip_ren_o,
    output logic [FLIP_ADDR_W-1:0] flip_raddr_o,
    input  spin_t                  flip_rdata_i,
    output logic                   cand_valid_o,
    input  logic                   cand_ready_i,
    output spin_t                  cand_o,
    input  logic                   result_valid_i,
    output logic                   result_ready_o,
    input  cand_t                  result_i,
    output logic                   cmpt_idle_o,
    output logic                   energy_update_o,
    output cand_t                  best_o
);

    fm_state_e            state_q;
    logic                 cmpt_en_q;
    logic                 start;
    logic                 flip_wait_q;
    logic [FLIP_ADDR_W:0] flip_cnt_q;
    logic                 update_q;
    spin_t                cur_q;
    spin_t                cand_q;
    cand_t                best_q;
    logic                 result_hs;
    logic                 accept;
    logic                 flip_load;

    assign start     = cmpt_en_i & ~cmpt_en_q;
    assign result_hs = result_valid_i & result_ready_o;

    // strictly lower energy wins, unless comparison is bypassed
    assign accept = ~en_comparison_i | (result_i.energy < best_q.energy);

    // second cycle of the flip read, icon row is on flip_rdata_i
    assign flip_load = (state_q == READ_FLIP) & flip_wait_q;

    assign cand_valid_o    = state_q == ISSUE;
    assign cand_o          = cand_q;
    assign result_ready_o  = state_q == WAIT_ENERGY;
    assign flip_ren_o      = (state_q == READ_FLIP) & ~flip_wait_q;
    assign flip_raddr_o    = flip_cnt_q[FLIP_ADDR_W-1:0];
    assign cmpt_idle_o     = state_q == IDLE;
    assign energy_update_o = update_q;
    assign best_o          = best_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            cmpt_en_q   <= 1'b0;
            flip_wait_q <= 1'b0;
            flip_cnt_q  <= '0;
            update_q    <= 1'b0;
        end else begin
            cmpt_en_q <= cmpt_en_i;
            update_q  <= result_hs & accept;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q    <= ISSUE;
                        flip_cnt_q <= '0;
                    end
                end
                ISSUE: begin
                    if (cand_ready_i) begin
                        state_q <= WAIT_ENERGY;
                    end
                end
                WAIT_ENERGY: begin
                    if (result_valid_i) begin
                        if (flip_cnt_q < flip_count_i) begin
                            state_q <= READ_FLIP;
                        end else begin
                            state_q <= DONE;
                        end
                    end
                end
                READ_FLIP: begin
                    flip_wait_q <= ~flip_wait_q;
                    if (flip_wait_q) begin
                        state_q    <= ISSUE;
                        flip_cnt_q <= flip_cnt_q + (FLIP_ADDR_W+1)'(1);
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (start) begin
                best_q.energy <= ENERGY_MAX;
                cand_q        <= cur_q;
            end else if (cfg_valid_i) begin
                cur_q <= cfg_spin_i;
            end
        end
        if (result_hs && accept) begin
            best_q <= result_i;
            cur_q  <= result_i.spin;
        end
        // cur_q already holds any accepted candidate here
        if (flip_load) begin
            cand_q <= cur_q ^ flip_rdata_i;
        end
    end

endmodule

/* design/digital_macro.sv */
// digital core of the Ising compute macro
// J weight fetch, energy monitor and flip manager

module digital_macro
    import ising_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cfg_valid_i,
    input  spin_t                  cfg_spin_i,
    input  logic                   cmpt_en_i,
    input  logic                   en_comparison_i,
    input  logic [FLIP_ADDR_W:0]   flip_count_i,
    input  h_vec_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    output logic                   j_ren_o,
    output logic [J_ADDR_W-1:0]    j_raddr_o,
    input  j_word_t                j_rdata_i,
    output logic                   flip_ren_o,
    output logic [FLIP_ADDR_W-1:0] flip_raddr_o,
    input  spin_t                  flip_rdata_i,
    output logic                   cmpt_idle_o,
    output logic                   energy_update_o,
    output cand_t                  best_o
);

    logic    word_valid;
    logic    word_ready;
    j_word_t word;
    logic    cand_valid;
    logic    cand_ready;
    spin_t   cand;
    logic    res_valid;
    logic    res_ready;
    cand_t   res;

    weight_fetch u_weight_fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .j_ren_o      (j_ren_o),
        .j_raddr_o    (j_raddr_o),
        .j_rdata_i    (j_rdata_i),
        .word_valid_o (word_valid),
        .word_ready_i (word_ready),
        .word_o       (word)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .spin_valid_i   (cand_valid),
        .spin_ready_o   (cand_ready),
        .spin_i         (cand),
        .word_valid_i   (word_valid),
        .word_ready_o   (word_ready),
        .word_i         (word),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .result_valid_o (res_valid),
        .result_ready_i (res_ready),
        .result_o       (res)
    );

    flip_manager u_flip_manager (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cfg_valid_i     (cfg_valid_i),
        .cfg_spin_i      (cfg_spin_i),
        .cmpt_en_i       (cmpt_en_i),
        .en_comparison_i (en_comparison_i),
        .flip_count_i    (flip_count_i),
        .flip_ren_o      (flip_ren_o),
        .flip_raddr_o    (flip_raddr_o),
        .flip_rdata_i    (flip_rdata_i),
        .cand_valid_o    (cand_valid),
        .cand_ready_i    (cand_ready),
        .cand_o          (cand),
        .result_valid_i  (res_valid),
        .result_ready_o  (res_ready),
        .result_i        (res),
        .cmpt_idle_o     (cmpt_idle_o),
        .energy_update_o (energy_update_o),
        .best_o          (best_o)
    );

endmodule

/* verif/digital_macro_assertions.sv */
// concurrent checks on the flip manager
// candidate handshake, idle hold, update pulse, flip read timing

module digital_macro_assertions
    import ising_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input fm_state_e state_i,
    input logic      cmpt_en_i,
    input logic      cand_valid_i,
    input logic      cand_ready_i,
    input logic      cmpt_idle_i,
    input logic      energy_update_i,
    input logic      flip_ren_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // candidate stays offered until taken
    cand_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        cand_valid_i && !cand_ready_i |=> cand_valid_i)
        else $error("candidate valid dropped before ready");

    // idle holds until a rising edge of cmpt_en
    idle_flag: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == IDLE && !$rose(cmpt_en_i) |=> cmpt_idle_i)
        else $error("left idle without a start edge");

    update_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        energy_update_i |=> !energy_update_i)
        else $error("energy_update_o high for two cycles");

    // one-cycle read strobe, next candidate two cycles later
    flip_read: assert property (@(posedge clk_i) disable iff (rst_i)
        flip_ren_i |=> (state_i == READ_FLIP && !flip_ren_i) ##1 cand_valid_i)
        else $error("flip read did not end in a candidate issue");

endmodule

bind flip_manager digital_macro_assertions u_assertions (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .state_i         (state_q),
    .cmpt_en_i       (cmpt_en_i),
    .cand_valid_i    (cand_valid_o),
    .cand_ready_i    (cand_ready_i),
    .cmpt_idle_i     (cmpt_idle_o),
    .energy_update_i (energy_update_o),
    .flip_ren_i      (flip_ren_o)
);

/* verif/tb_digital_macro.sv */
// testbench for the Ising digital macro
// clock, reset, J and flip memory models, reference energy
// directed tests with replay of the greedy search, watchdog

module tb_digital_macro
    import ising_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'h4cea_1095;
    // generous bound for one candidate: issue, energy, flip read
    localparam int          ITER_CYCLES  = 32;
    // candidates over all runs, 1 + 13 + 13 + 21 + 9 + 9
    localparam int          TOTAL_ITERS  = 66;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_ITERS * ITER_CYCLES + 200;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cfg_valid;
    spin_t                  cfg_spin;
    logic                   cmpt_en;
    logic                   en_comparison;
    logic [FLIP_ADDR_W:0]   flip_count;
    h_vec_t                 hbias;
    logic [SCALING_BIT-1:0] hscaling;
    logic                   j_ren;
    logic [J_ADDR_W-1:0]    j_raddr;
    j_word_t                j_rdata = '0;
    logic                   flip_ren;
    logic [FLIP_ADDR_W-1:0] flip_raddr;
    spin_t                  flip_rdata = '0;
    logic                   cmpt_idle;
    logic                   energy_update;
    cand_t                  best;

    j_word_t     j_mem [J_DEPTH];
    spin_t       flip_mem [FLIP_DEPTH];
    int          jmat [NUM_SPIN][NUM_SPIN];
    int          h_val [NUM_SPIN];
    int          scale_val;
    logic [31:0] lfsr_q;
    int          upd_total = 0;
    int          errors = 0;
    int          n_tests = 0;

    always #10 clk = ~clk;

    digital_macro digital_macro_i (
        .clk_i           (clk),
        .rst_i           (rst),
        .cfg_valid_i     (cfg_valid),
        .cfg_spin_i      (cfg_spin),
        .cmpt_en_i       (cmpt_en),
        .en_comparison_i (en_comparison),
        .flip_count_i    (flip_count),
        .hbias_i         (hbias),
        .hscaling_i      (hscaling),
        .j_ren_o         (j_ren),
        .j_raddr_o       (j_raddr),
        .j_rdata_i       (j_rdata),
        .flip_ren_o      (flip_ren),
        .flip_raddr_o    (flip_raddr),
        .flip_rdata_i    (flip_rdata),
        .cmpt_idle_o     (cmpt_idle),
        .energy_update_o (energy_update),
        .best_o          (best)
    );

    // both memories answer one cycle after ren
    always @(posedge clk) begin
        if (j_ren) begin
            j_rdata <= j_mem[j_raddr];
        end
        if (flip_ren) begin
            flip_rdata <= flip_mem[flip_raddr];
        end
        if (energy_update) begin
            upd_total <= upd_total + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_q[0]};
            if (lfsr_q[0]) begin
                lfsr_q = (lfsr_q >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_q = lfsr_q >> 1;
            end
        end
        return v;
    endfunction

    // E = sum_i sigma_i * (sum_j J_ij sigma_j + s * h_i)
    function automatic int ref_energy(input spin_t s);
        int sigma [NUM_SPIN];
        int field;
        int e;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            sigma[i] = s[i] ? 1 : -1;
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = scale_val * h_val[i];
            for (int j = 0; j < NUM_SPIN; j++) begin
                field += jmat[i][j] * sigma[j];
            end
            e += sigma[i] * field;
        end
        return e;
    endfunction

    task automatic fill_memories();
        lfsr_q = SEED;
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                jmat[i][j] = int'(coef_t'(rand_bits(BITJ)));
                j_mem[i / PARALLELISM][i % PARALLELISM][j] = coef_t'(jmat[i][j]);
            end
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            h_val[i] = int'(coef_t'(rand_bits(BITJ)));
            hbias[i] = coef_t'(h_val[i]);
        end
        scale_val = int'(rand_bits(SCALING_BIT));
        hscaling  = SCALING_BIT'(scale_val);
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            flip_mem[k] = spin_t'(rand_bits(NUM_SPIN));
        end
    endtask

    // acceptance rule applied to the whole candidate chain
    task automatic replay_search(input spin_t start, input int count, input bit comp,
                                 output cand_t exp, output spin_t cur, output int accepts);
        spin_t cand;
        int    e;
        exp     = '{spin: start, energy: ENERGY_MAX};
        cur     = start;
        accepts = 0;
        for (int k = 0; k <= count; k++) begin
            cand = (k == 0) ? start : cur ^ flip_mem[k - 1];
            e    = ref_energy(cand);
            if (!comp || energy_t'(e) < exp.energy) begin
                exp = '{spin: cand, energy: energy_t'(e)};
                cur = cand;
                accepts++;
            end
        end
    endtask

    task automatic check_equal(input string sig, input logic signed [63:0] exp,
                               input logic signed [63:0] got);
        assert (exp === got) else begin
            $display("ERR %0t %s expected %0d actual %0d", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_best(input cand_t exp);
        check_equal("best_o.spin", exp.spin, best.spin);
        check_equal("best_o.energy", int'(exp.energy), int'(best.energy));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // optional spin load, start edge, then wait for idle
    task automatic run_search(input bit load, input spin_t s, input int count, input bit comp,
                              output int pulses);
        int cycles;
        int upd_start;
        @(posedge clk);
        cfg_valid     <= load;
        cfg_spin      <= s;
        flip_count    <= (FLIP_ADDR_W+1)'(count);
        en_comparison <= comp;
        @(posedge clk);
        cfg_valid <= 1'b0;
        cmpt_en   <= 1'b1;
        upd_start = upd_total;
        repeat (2) @(posedge clk);
        cycles = 0;
        while (!cmpt_idle && cycles < (count + 1) * ITER_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        cmpt_en <= 1'b0;
        pulses = upd_total - upd_start;
        assert (cmpt_idle) else begin
            $display("search with %0d flips did not return to idle in time", count);
            errors++;
        end
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        check_equal("cmpt_idle_o", 1, cmpt_idle);
        check_equal("energy_update_o", 0, energy_update);
        check_equal("j_ren_o", 0, j_ren);
        check_equal("flip_ren_o", 0, flip_ren);
        finish_test("reset_values", e0);
    endtask

    task automatic zero_flips();
        int    e0;
        int    pulses;
        spin_t s;
        e0 = errors;
        s  = spin_t'(rand_bits(NUM_SPIN));
        run_search(1'b1, s, 0, 1'b1, pulses);
        check_equal("best_o.spin", s, best.spin);
        check_equal("best_o.energy", ref_energy(s), int'(best.energy));
        finish_test("zero_flips", e0);
    endtask

    task automatic greedy_search(input spin_t s);
        int    e0;
        int    pulses;
        int    accepts;
        cand_t exp;
        spin_t cur;
        e0 = errors;
        replay_search(s, 12, 1'b1, exp, cur, accepts);
        run_search(1'b1, s, 12, 1'b1, pulses);
        check_best(exp);
        finish_test("greedy_search", e0);
    endtask

    // every candidate is taken, best is the chain's last one
    task automatic comparison_off(input spin_t s);
        int    e0;
        int    pulses;
        int    accepts;
        cand_t exp;
        spin_t cur;
        e0 = errors;
        replay_search(s, 12, 1'b0, exp, cur, accepts);
        run_search(1'b1, s, 12, 1'b0, pulses);
        check_best(exp);
        finish_test("comparison_off", e0);
    endtask

    task automatic update_pulses();
        int    e0;
        int    pulses;
        int    accepts;
        cand_t exp;
        spin_t cur;
        spin_t s;
        e0 = errors;
        s  = spin_t'(rand_bits(NUM_SPIN));
        replay_search(s, 20, 1'b1, exp, cur, accepts);
        run_search(1'b1, s, 20, 1'b1, pulses);
        check_best(exp);
        check_equal("energy_update_o pulses", accepts, pulses);
        finish_test("update_pulses", e0);
    endtask

    // second run starts from the kept current spin
    task automatic back_to_back();
        int    e0;
        int    pulses;
        int    accepts;
        cand_t exp;
        spin_t cur;
        spin_t s;
        e0 = errors;
        s  = spin_t'(rand_bits(NUM_SPIN));
        replay_search(s, 8, 1'b1, exp, cur, accepts);
        run_search(1'b1, s, 8, 1'b1, pulses);
        check_best(exp);
        replay_search(cur, 8, 1'b1, exp, cur, accepts);
        run_search(1'b0, '0, 8, 1'b1, pulses);
        check_best(exp);
        check_equal("energy_update_o pulses", accepts, pulses);
        finish_test("back_to_back", e0);
    endtask

    initial begin
        spin_t chain;
        rst           = 1'b1;
        cfg_valid     = 1'b0;
        cfg_spin      = '0;
        cmpt_en       = 1'b0;
        en_comparison = 1'b0;
        flip_count    = '0;
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_values();
        rst <= 1'b0;
        zero_flips();
        chain = spin_t'(rand_bits(NUM_SPIN));
        greedy_search(chain);
        comparison_off(chain);
        update_pulses();
        back_to_back();
        $display("tests run %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* digital_macro.f */
design/ising_pkg.sv
design/weight_fetch.sv
design/energy_monitor.sv
design/flip_manager.sv
design/digital_macro.sv
verif/digital_macro_assertions.sv
verif/tb_digital_macro.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the digital macro testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_digital_macro -f digital_macro.f \
    --Mdir obj_dir -o tb_digital_macro > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_digital_macro > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation passed"
exit 0
